// ==== Makefile ====
# Verilator build and run for the SRAM command front end testbench

VERILATOR ?= verilator
TOP       ?= tb_sram_ctl
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --timescale 1ns/100ps

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "TESTBENCH PASSED" $(LOG); then echo "simulation did not finish"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== all.f ====
rtl/sram_ctl_pkg.sv
rtl/array_port_decode.sv
rtl/read_sequencer.sv
rtl/read_return_mux.sv
rtl/sram_ctl_top.sv
test/sram_array_model.sv
test/tb_sram_ctl.sv

// ==== rtl/array_port_decode.sv ====
// command decode stage
// array port strobes, side register strobes, read request and kind

`timescale 1ns/100ps

module array_port_decode (
  input  logic                            ctl_cmd_val,
  input  logic                            ra_cmd_val,
  input  sram_ctl_pkg::adr_t              cmd_adr,
  input  logic                            cmd_we,
  input  logic [sram_ctl_pkg::sel_w-1:0]  cmd_sel,
  input  sram_ctl_pkg::data_t             cmd_dat,
  output logic                            ra_r0_enb,
  output logic                            ra_r1_enb,
  output logic                            ra_w0_enb,
  output sram_ctl_pkg::row_t              ra_r0_adr,
  output sram_ctl_pkg::row_t              ra_r1_adr,
  output sram_ctl_pkg::row_t              ra_w0_adr,
  output sram_ctl_pkg::data_t             ra_w0_dat,
  output sram_ctl_pkg::data_t             ra_cfg_wdat,
  output sram_ctl_pkg::data_t             ra_bist_ctl,
  output logic                            ra_cfg_wr,
  output logic                            cfg0_wr,
  output logic                            rd_req,
  output sram_ctl_pkg::rd_kind_t          rd_kind
);
  import sram_ctl_pkg::*;

  logic       adr_bist;
  logic       adr_cfg;
  logic       special;
  logic       ra_rd;
  logic [1:0] rd_type;

  // region match on bits 15:12
  assign adr_bist = (cmd_adr & adr_mask) == (bist_adr & adr_mask);
  assign adr_cfg  = (cmd_adr & adr_mask) == (cfg_adr & adr_mask);
  assign special  = adr_bist | adr_cfg;

  // 00 r0, 01 r1, 10 lo pack, 11 hi pack
  assign rd_type = cmd_adr[15:14];

  // plain array read, side regions excluded
  assign ra_rd = ra_cmd_val & ~cmd_we & ~special;

  // r0 is used by every type except r1 alone
  assign ra_r0_enb = ra_rd & (rd_type != 2'b01);
  // r1 is used by every type except r0 alone
  assign ra_r1_enb = ra_rd & (rd_type != 2'b00);

  // row in bits 6:2
  assign ra_r0_adr = cmd_adr[6:2];
  // packed reads take the second row from bits 14:10
  assign ra_r1_adr = (rd_type == 2'b01) ? cmd_adr[6:2] : cmd_adr[14:10];

  // write needs at least one byte lane
  assign ra_w0_enb = ra_cmd_val & cmd_we & ~special & (|cmd_sel);
  assign ra_w0_adr = cmd_adr[6:2];
  assign ra_w0_dat = cmd_dat;

  // BIST control bus idles at zero between writes
  assign ra_bist_ctl = (ra_cmd_val & cmd_we & adr_bist) ? cmd_dat : '0;

  // macro config write
  assign ra_cfg_wr   = ra_cmd_val & cmd_we & adr_cfg;
  assign ra_cfg_wdat = cmd_dat;

  // cfg0 matched on the offset with the region bits masked off
  assign cfg0_wr = ctl_cmd_val & cmd_we & ((cmd_adr & ~adr_mask) == cfg0_adr);

  // any read of either space goes to the sequencer
  assign rd_req = (ctl_cmd_val | ra_cmd_val) & ~cmd_we;

  // read classification
  // side regions win in either space so BIST status reads from both
  always_comb begin
    if (adr_bist) begin
      rd_kind = rd_bist;
    end else if (adr_cfg) begin
      rd_kind = rd_cfg;
    end else if (ctl_cmd_val) begin
      rd_kind = rd_ctl;
    end else begin
      case (rd_type)
        2'b00:   rd_kind = rd_r0;
        2'b01:   rd_kind = rd_r1;
        2'b10:   rd_kind = rd_lo;
        default: rd_kind = rd_hi;
      endcase
    end
  end

endmodule

// ==== rtl/read_return_mux.sv ====
// read return stage
// selects and packs read data for the latched read kind

`timescale 1ns/100ps

module read_return_mux (
  input  sram_ctl_pkg::rd_kind_t  sel_kind,
  input  sram_ctl_pkg::data_t     ra_r0_dat,
  input  sram_ctl_pkg::data_t     ra_r1_dat,
  input  sram_ctl_pkg::data_t     cfg0,
  input  sram_ctl_pkg::data_t     ra_bist_status,
  input  sram_ctl_pkg::data_t     ra_cfg_rdat,
  output sram_ctl_pkg::data_t     rd_dat
);
  import sram_ctl_pkg::*;

  localparam int half_w = data_w / 2;

  always_comb begin
    case (sel_kind)
      rd_r0: begin
        rd_dat = ra_r0_dat;
      end
      rd_r1: begin
        rd_dat = ra_r1_dat;
      end
      // r1 low half on top of r0 low half
      rd_lo: begin
        rd_dat = {ra_r1_dat[half_w-1:0], ra_r0_dat[half_w-1:0]};
      end
      // r1 high half on top of r0 high half
      rd_hi: begin
        rd_dat = {ra_r1_dat[data_w-1:half_w], ra_r0_dat[data_w-1:half_w]};
      end
      rd_ctl: begin
        rd_dat = cfg0;
      end
      rd_bist: begin
        rd_dat = ra_bist_status;
      end
      rd_cfg: begin
        rd_dat = ra_cfg_rdat;
      end
      // unused encoding reads back all ones
      default: begin
        rd_dat = '1;
      end
    endcase
  end

endmodule

// ==== rtl/read_sequencer.sv ====
// read sequence stage
// cfg0 register, read FSM, wait counter and acknowledge

`timescale 1ns/100ps

module read_sequencer (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    rd_req,
  input  sram_ctl_pkg::rd_kind_t  rd_kind,
  input  logic                    cfg0_wr,
  input  sram_ctl_pkg::data_t     cfg0_wdat,
  output logic                    rd_ack,
  output sram_ctl_pkg::rd_kind_t  sel_kind,
  output sram_ctl_pkg::data_t     cfg0
);
  import sram_ctl_pkg::*;

  seq_state_t state_q;
  seq_state_t state_d;
  wait_t      cnt_q;
  wait_t      cnt_d;
  rd_kind_t   kind_q;
  data_t      cfg0_q;
  logic       accept;
  logic       cnt_zero;

  // only one read in flight
  // a request while waiting is dropped
  assign accept = (state_q == seq_idle) & rd_req;

  assign cnt_zero = (cnt_q == '0);

  // next state and counter
  always_comb begin
    state_d = state_q;
    cnt_d   = cnt_q;
    case (state_q)
      seq_idle: begin
        if (rd_req) begin
          state_d = seq_wait;
          // wait count comes from cfg0 as it stands at the command edge
          cnt_d   = cfg0_q[wait_w-1:0];
        end
      end
      seq_wait: begin
        if (cnt_zero) begin
          state_d = seq_idle;
        end else begin
          cnt_d = cnt_q - 1'b1;
        end
      end
      default: begin
        state_d = seq_idle;
      end
    endcase
  end

  // FSM registers
  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= seq_idle;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
    end
  end

  // kind held for the return mux until the next accepted read
  always_ff @(posedge clk) begin
    if (rst) begin
      kind_q <= rd_ctl;
    end else if (accept) begin
      kind_q <= rd_kind;
    end
  end

  // cfg0
  // 31:3 reserved
  // 2:0 read wait cycles after the command cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      cfg0_q <= cfg0_init;
    end else if (cfg0_wr) begin
      cfg0_q <= cfg0_wdat;
    end
  end

  // single cycle ack on the last wait cycle
  // W+1 edges after the edge that took the command
  assign rd_ack = (state_q == seq_wait) & cnt_zero;

  assign sel_kind = kind_q;
  assign cfg0     = cfg0_q;

endmodule

// ==== rtl/sram_ctl_pkg.sv ====
// shared definitions for the SRAM command front end
// address map constants and field widths
// vector typedefs, read kind and sequencer state enums

package sram_ctl_pkg;

  // command and read data width
  localparam int data_w = 32;

  // 32 rows per array port
  localparam int row_w = 5;

  // one select per data byte
  localparam int sel_w = 4;

  // read wait field held in cfg0 bits 2:0
  localparam int wait_w = 3;

  // region field of the command address
  localparam logic [31:0] adr_mask = 32'h0000_F000;

  // macro config register region
  localparam logic [31:0] cfg_adr = 32'h0000_E000;

  // BIST control and status region
  localparam logic [31:0] bist_adr = 32'h0000_F000;

  // cfg0 offset inside controller space
  // compared with the region bits cleared
  localparam logic [31:0] cfg0_adr = 32'h0000_0000;

  // one wait cycle out of reset
  localparam logic [31:0] cfg0_init = 32'h0000_0001;

  typedef logic [data_w-1:0] data_t;
  typedef logic [31:0] adr_t;
  typedef logic [row_w-1:0] row_t;
  typedef logic [wait_w-1:0] wait_t;

  // what a read returns
  // controller side registers first, then the array port reads
  typedef enum logic [2:0] {
    // cfg0
    rd_ctl,
    // BIST status
    rd_bist,
    // macro config readback
    rd_cfg,
    // r0 port alone
    rd_r0,
    // r1 port alone
    rd_r1,
    // r0 and r1 low halves packed
    rd_lo,
    // r0 and r1 high halves packed
    rd_hi
  } rd_kind_t;

  // read sequencer states
  typedef enum logic {
    seq_idle,
    seq_wait
  } seq_state_t;

endpackage

// ==== rtl/sram_ctl_top.sv ====
// SRAM command front end top level
// decode, sequence and return stages between host and array ports

`timescale 1ns/100ps

module sram_ctl_top (
  input  logic                            clk,
  input  logic                            rst,

  // host command side
  input  logic                            ctl_cmd_val,
  input  logic                            ra_cmd_val,
  input  sram_ctl_pkg::adr_t              cmd_adr,
  input  logic                            cmd_we,
  input  logic [sram_ctl_pkg::sel_w-1:0]  cmd_sel,
  input  sram_ctl_pkg::data_t             cmd_dat,
  output logic                            rd_ack,
  output sram_ctl_pkg::data_t             rd_dat,

  // array read ports
  output logic                            ra_r0_enb,
  output sram_ctl_pkg::row_t              ra_r0_adr,
  input  sram_ctl_pkg::data_t             ra_r0_dat,
  output logic                            ra_r1_enb,
  output sram_ctl_pkg::row_t              ra_r1_adr,
  input  sram_ctl_pkg::data_t             ra_r1_dat,

  // array write port
  output logic                            ra_w0_enb,
  output sram_ctl_pkg::row_t              ra_w0_adr,
  output sram_ctl_pkg::data_t             ra_w0_dat,

  // macro config and BIST
  output logic                            ra_cfg_wr,
  output sram_ctl_pkg::data_t             ra_cfg_wdat,
  input  sram_ctl_pkg::data_t             ra_cfg_rdat,
  output sram_ctl_pkg::data_t             ra_bist_ctl,
  input  sram_ctl_pkg::data_t             ra_bist_status
);
  import sram_ctl_pkg::*;

  // decode to sequencer
  logic     rd_req;
  rd_kind_t rd_kind;
  logic     cfg0_wr;

  // sequencer to return mux
  rd_kind_t sel_kind;
  data_t    cfg0;

  // zero latency decode of the command cycle
  array_port_decode u_decode (
    .ctl_cmd_val (ctl_cmd_val),
    .ra_cmd_val  (ra_cmd_val),
    .cmd_adr     (cmd_adr),
    .cmd_we      (cmd_we),
    .cmd_sel     (cmd_sel),
    .cmd_dat     (cmd_dat),
    .ra_r0_enb   (ra_r0_enb),
    .ra_r1_enb   (ra_r1_enb),
    .ra_w0_enb   (ra_w0_enb),
    .ra_r0_adr   (ra_r0_adr),
    .ra_r1_adr   (ra_r1_adr),
    .ra_w0_adr   (ra_w0_adr),
    .ra_w0_dat   (ra_w0_dat),
    .ra_cfg_wdat (ra_cfg_wdat),
    .ra_bist_ctl (ra_bist_ctl),
    .ra_cfg_wr   (ra_cfg_wr),
    .cfg0_wr     (cfg0_wr),
    .rd_req      (rd_req),
    .rd_kind     (rd_kind)
  );

  // cfg0 write data taken straight from the host bus
  read_sequencer u_seq (
    .clk       (clk),
    .rst       (rst),
    .rd_req    (rd_req),
    .rd_kind   (rd_kind),
    .cfg0_wr   (cfg0_wr),
    .cfg0_wdat (cmd_dat),
    .rd_ack    (rd_ack),
    .sel_kind  (sel_kind),
    .cfg0      (cfg0)
  );

  // array read data is already registered by the array
  read_return_mux u_ret (
    .sel_kind       (sel_kind),
    .ra_r0_dat      (ra_r0_dat),
    .ra_r1_dat      (ra_r1_dat),
    .cfg0           (cfg0),
    .ra_bist_status (ra_bist_status),
    .ra_cfg_rdat    (ra_cfg_rdat),
    .rd_dat         (rd_dat)
  );

endmodule

// ==== test/sram_array_model.sv ====
// behavioral test array for the SRAM command front end
// 32 rows, one byte-masked write port, two registered read ports
// BIST control mirrored as status, macro config register

`timescale 1ns/100ps

module sram_array_model (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            ra_r0_enb,
  input  sram_ctl_pkg::row_t              ra_r0_adr,
  output sram_ctl_pkg::data_t             ra_r0_dat,
  input  logic                            ra_r1_enb,
  input  sram_ctl_pkg::row_t              ra_r1_adr,
  output sram_ctl_pkg::data_t             ra_r1_dat,
  input  logic                            ra_w0_enb,
  input  sram_ctl_pkg::row_t              ra_w0_adr,
  input  sram_ctl_pkg::data_t             ra_w0_dat,
  input  logic [sram_ctl_pkg::sel_w-1:0]  ra_w0_sel,
  input  sram_ctl_pkg::data_t             ra_bist_ctl,
  output sram_ctl_pkg::data_t             ra_bist_status,
  input  logic                            ra_cfg_wr,
  input  sram_ctl_pkg::data_t             ra_cfg_wdat,
  output sram_ctl_pkg::data_t             ra_cfg_rdat
);
  import sram_ctl_pkg::*;

  data_t mem [0:31];

  // byte lanes written only where selected
  always_ff @(posedge clk) begin
    if (ra_w0_enb) begin
      for (int b = 0; b < sel_w; b++) begin
        if (ra_w0_sel[b]) begin
          mem[ra_w0_adr][8*b +: 8] <= ra_w0_dat[8*b +: 8];
        end
      end
    end
    // read data held until the next enabled read
    if (ra_r0_enb) begin
      ra_r0_dat <= mem[ra_r0_adr];
    end
    if (ra_r1_enb) begin
      ra_r1_dat <= mem[ra_r1_adr];
    end
  end

  // a zero on the BIST control bus is idle
  always_ff @(posedge clk) begin
    if (rst) begin
      ra_bist_status <= '0;
      ra_cfg_rdat    <= '0;
    end else begin
      if (ra_bist_ctl != '0) begin
        ra_bist_status <= ra_bist_ctl;
      end
      if (ra_cfg_wr) begin
        ra_cfg_rdat <= ra_cfg_wdat;
      end
    end
  end

endmodule

// ==== test/tb_sram_ctl.sv ====
// testbench for the SRAM command front end
// clock, reset, host command tasks, check task and directed tests

`timescale 1ns/100ps

module tb_sram_ctl;
  import sram_ctl_pkg::*;

  // longest wait is 7, so ack comes within 8 cycles
  localparam int ack_timeout = 16;

  logic             clk;
  logic             rst;
  logic             ctl_cmd_val;
  logic             ra_cmd_val;
  adr_t             cmd_adr;
  logic             cmd_we;
  logic [sel_w-1:0] cmd_sel;
  data_t            cmd_dat;
  logic             rd_ack;
  data_t            rd_dat;
  logic             ra_r0_enb;
  logic             ra_r1_enb;
  logic             ra_w0_enb;
  logic             ra_cfg_wr;
  row_t             ra_r0_adr;
  row_t             ra_r1_adr;
  row_t             ra_w0_adr;
  data_t            ra_r0_dat;
  data_t            ra_r1_dat;
  data_t            ra_w0_dat;
  data_t            ra_cfg_wdat;
  data_t            ra_cfg_rdat;
  data_t            ra_bist_ctl;
  data_t            ra_bist_status;

  // expected array rows and cfg0
  data_t row_mirror [0:31];
  data_t cfg0_mirror;

  // array strobes seen at the edge that took the last command
  logic  seen_r0_enb;
  logic  seen_r1_enb;
  logic  seen_w0_enb;
  data_t seen_bist_ctl;

  sram_ctl_top DUT (.*);

  // byte selects go to the array straight from the host bus
  sram_array_model u_array (.*, .ra_w0_sel(cmd_sel));

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic fail_run();
    $display("TESTBENCH FAILED");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input data_t got, input data_t exp);
    if (got !== exp) begin
      $display("ERROR at time %0t: %s is 0x%08h, expected 0x%08h", $time, name, got, exp);
      fail_run();
    end
  endtask

  task automatic drive_idle();
    ctl_cmd_val = 1'b0;
    ra_cmd_val  = 1'b0;
    cmd_adr     = '0;
    cmd_we      = 1'b0;
    cmd_sel     = '0;
    cmd_dat     = '0;
  endtask

  // array strobes are decoded from the host bus alone
  // so they are settled by the rising edge
  task automatic capture_strobes();
    @(posedge clk);
    seen_r0_enb   = ra_r0_enb;
    seen_r1_enb   = ra_r1_enb;
    seen_w0_enb   = ra_w0_enb;
    seen_bist_ctl = ra_bist_ctl;
  endtask

  // one command cycle, taken on the next rising edge
  task automatic send_cmd(input logic ctl, input adr_t adr, input logic we,
                          input logic [sel_w-1:0] sel, input data_t dat);
    @(negedge clk);
    ctl_cmd_val = ctl;
    ra_cmd_val  = ~ctl;
    cmd_adr     = adr;
    cmd_we      = we;
    cmd_sel     = sel;
    cmd_dat     = dat;
    capture_strobes();
  endtask

  task automatic write_cmd(input logic ctl, input adr_t adr, input logic [sel_w-1:0] sel,
                           input data_t dat);
    send_cmd(ctl, adr, 1'b1, sel, dat);
    @(negedge clk);
    drive_idle();
  endtask

  // ack expected W+1 cycles after the command, then low again
  task automatic read_cmd(input logic ctl, input adr_t adr, output data_t dat);
    int   cycles;
    logic seen;
    cycles = 0;
    seen   = 1'b0;
    send_cmd(ctl, adr, 1'b0, '0, '0);
    while (!seen && cycles < ack_timeout) begin
      @(negedge clk);
      drive_idle();
      cycles++;
      seen = rd_ack;
    end
    if (!seen) begin
      $display("timeout, no rd_ack within %0d cycles of the read at 0x%08h", ack_timeout, adr);
      fail_run();
    end else begin
      dat = rd_dat;
      check_value("rd_ack latency", data_t'(cycles),
                  data_t'(cfg0_mirror[wait_w-1:0]) + 32'd1);
      @(negedge clk);
      check_value("rd_ack", data_t'(rd_ack), '0);
    end
  endtask

  task automatic write_cfg0(input data_t v);
    write_cmd(1'b1, cfg0_adr, '1, v);
    cfg0_mirror = v;
  endtask

  // row in address bits 6:2
  task automatic write_row(input row_t row, input logic [sel_w-1:0] sel, input data_t dat);
    write_cmd(1'b0, adr_t'({row, 2'b00}), sel, dat);
    for (int b = 0; b < sel_w; b++) begin
      if (sel[b]) begin
        row_mirror[row][8*b +: 8] = dat[8*b +: 8];
      end
    end
  endtask

  task automatic cfg0_readback();
    data_t got;
    data_t v;
    read_cmd(1'b1, cfg0_adr, got);
    check_value("rd_dat cfg0 after reset", got, cfg0_init);
    v = $urandom();
    v[wait_w-1:0] = 3'd2;
    write_cfg0(v);
    read_cmd(1'b1, cfg0_adr, got);
    check_value("rd_dat cfg0", got, v);
  endtask

  task automatic ack_latency();
    logic [8:0] waits = {3'd7, 3'd3, 3'd0};
    data_t      got;
    data_t      v;
    for (int i = 0; i < 3; i++) begin
      v = $urandom();
      v[wait_w-1:0] = waits[3*i +: 3];
      write_cfg0(v);
      read_cmd(1'b1, cfg0_adr, got);
      check_value("rd_dat cfg0", got, v);
    end
    write_cfg0(cfg0_init);
  endtask

  task automatic row_reads();
    data_t got;
    row_t  r;
    for (int i = 0; i < 32; i++) begin
      write_row(row_t'(i), '1, $urandom());
    end
    for (int i = 0; i < 8; i++) begin
      r = row_t'($urandom());
      read_cmd(1'b0, adr_t'({r, 2'b00}), got);
      check_value("rd_dat r0", got, row_mirror[r]);
      check_value("ra_r1_enb on r0 read", data_t'(seen_r1_enb), '0);
      r = row_t'($urandom());
      // read type 01 in bits 15:14
      read_cmd(1'b0, adr_t'({2'b01, 7'd0, r, 2'b00}), got);
      check_value("rd_dat r1", got, row_mirror[r]);
      check_value("ra_r0_enb on r1 read", data_t'(seen_r0_enb), '0);
    end
  endtask

  // bit 14 is both the low read type bit and the r1 row msb
  // so lo takes r1 rows below 16 and hi rows 16 to 23
  // hi rows from 24 land in the config and BIST regions
  task automatic packed_reads();
    data_t got;
    row_t  r0;
    row_t  r1;
    for (int i = 0; i < 6; i++) begin
      r0 = row_t'($urandom());
      r1 = row_t'($urandom() % 16);
      if (r0 == r1) begin
        r0 = r0 + 5'd1;
      end
      read_cmd(1'b0, adr_t'({1'b1, r1, 3'd0, r0, 2'b00}), got);
      check_value("rd_dat lo", got, {row_mirror[r1][15:0], row_mirror[r0][15:0]});
      r1 = row_t'(16 + $urandom() % 8);
      if (r0 == r1) begin
        r0 = r0 + 5'd1;
      end
      read_cmd(1'b0, adr_t'({1'b1, r1, 3'd0, r0, 2'b00}), got);
      check_value("rd_dat hi", got, {row_mirror[r1][31:16], row_mirror[r0][31:16]});
    end
  endtask

  task automatic side_regs();
    data_t got;
    data_t v;
    v = $urandom() | 32'h1;
    write_cmd(1'b0, bist_adr, '1, v);
    check_value("ra_bist_ctl on BIST write", seen_bist_ctl, v);
    check_value("ra_w0_enb on BIST write", data_t'(seen_w0_enb), '0);
    read_cmd(1'b0, bist_adr, got);
    check_value("rd_dat bist status, array space", got, v);
    read_cmd(1'b1, bist_adr, got);
    check_value("rd_dat bist status, ctl space", got, v);
    check_value("ra_r0_enb on ctl read", data_t'(seen_r0_enb), '0);
    check_value("ra_r1_enb on ctl read", data_t'(seen_r1_enb), '0);
    v = $urandom();
    write_cmd(1'b0, cfg_adr, '1, v);
    check_value("ra_bist_ctl on config write", seen_bist_ctl, '0);
    read_cmd(1'b0, cfg_adr, got);
    check_value("rd_dat macro config", got, v);
  endtask

  // last pattern has no lanes, raises no write enable and leaves the row alone
  task automatic partial_writes();
    logic [15:0] sels = 16'b0000_0110_1000_0101;
    data_t       got;
    row_t        r;
    r = row_t'($urandom());
    for (int i = 0; i < 4; i++) begin
      write_row(r, sels[4*i +: 4], $urandom());
      check_value("ra_w0_enb", data_t'(seen_w0_enb), data_t'(sels[4*i +: 4] != '0));
      check_value("ra_bist_ctl on row write", seen_bist_ctl, '0);
      read_cmd(1'b0, adr_t'({r, 2'b00}), got);
      check_value("rd_dat r0 partial", got, row_mirror[r]);
    end
  endtask

  initial begin
    void'($urandom(88));
    rst = 1'b1;
    drive_idle();
    cfg0_mirror = cfg0_init;
    repeat (4) @(negedge clk);
    rst = 1'b0;
    cfg0_readback();
    ack_latency();
    row_reads();
    packed_reads();
    side_regs();
    partial_writes();
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule
